/* source/isaPkg.sv */
package isaPkg;

    // ------------------------------------------------------------
    // word and register file geometry
    // ------------------------------------------------------------
    localparam int WORD_W    = 14;
    localparam int WORD_MSB  = WORD_W - 1;     // sign bit
    localparam int REG_COUNT = 16;
    localparam int REG_W     = 4;
    localparam int OPC_W     = 6;

    // bit positions inside flagsT
    localparam int FLAG_C = 3;
    localparam int FLAG_N = 2;
    localparam int FLAG_V = 1;
    localparam int FLAG_Z = 0;

    typedef logic [WORD_W-1:0] wordT;
    typedef logic [REG_W-1:0]  regIdxT;
    typedef logic [3:0]        flagsT;         // carry, negative, overflow, zero

    typedef enum logic [OPC_W-1:0] {
        OP_NOP  = 6'h00,
        OP_CPY  = 6'h03,
        OP_ADD  = 6'h20,
        OP_SUB  = 6'h21,
        OP_ADDC = 6'h22,
        OP_SUBC = 6'h23,
        OP_NOT  = 6'h28,
        OP_AND  = 6'h29,
        OP_OR   = 6'h2A,
        OP_XOR  = 6'h2B,
        OP_SHLL = 6'h2C,
        OP_SHRL = 6'h2D,
        OP_SHLA = 6'h2E,
        OP_SHRA = 6'h2F,
        OP_ROTL = 6'h30,
        OP_ROTR = 6'h31,
        OP_RTLC = 6'h32,
        OP_RTRC = 6'h33
    } opcodeT;

    // ------------------------------------------------------------
    // instruction word, low field read two ways
    // ------------------------------------------------------------
    typedef struct packed {
        opcodeT opcode;
        regIdxT regA;                          // destination and operand A
        regIdxT regB;
    } regViewT;

    typedef struct packed {
        opcodeT           opcode;
        regIdxT           regA;
        logic [REG_W-1:0] imm;                 // immediate or shift count
    } immViewT;

    typedef union packed {
        regViewT regView;
        immViewT immView;
    } instrT;

    // second field is an immediate for these
    function automatic logic usesImm(opcodeT op);
        case (op)
            OP_ADDC, OP_SUBC,
            OP_SHLL, OP_SHRL, OP_SHLA, OP_SHRA,
            OP_ROTL, OP_ROTR, OP_RTLC, OP_RTRC: return 1'b1;
            default:                            return 1'b0;
        endcase
    endfunction

endpackage

/* source/flowPkg.sv */
package flowPkg;

    // ------------------------------------------------------------
    // instruction side
    // ------------------------------------------------------------
    localparam int QUEUE_DEPTH = 4;            // sender starts with this many credits
    localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);

    typedef logic [2:0] creditCountT;          // 0 up to 4

    // ------------------------------------------------------------
    // result side
    // ------------------------------------------------------------
    localparam creditCountT RES_CREDIT_MAX = 3'd4;

endpackage

/* source/instQueue.sv */
module instQueue
    import isaPkg::*;
    import flowPkg::*;
(
    input  logic  Clock_pin,
    input  logic  rstN,
    input  logic  instValid,
    input  instrT instWord,
    input  logic  qTake,
    output logic  qValid,
    output instrT qInstr,
    output logic  instCredit
);

    instrT                  slots [QUEUE_DEPTH];
    logic [QUEUE_PTR_W-1:0] wrPtr;
    logic [QUEUE_PTR_W-1:0] rdPtr;
    creditCountT            qCount;
    logic                   deq;

    assign qValid = (qCount != '0);
    assign qInstr = slots[rdPtr];
    assign deq    = qValid && qTake;

    // sender only writes while holding a credit, so a slot is always free
    always_ff @(posedge Clock_pin) begin
        if (instValid) begin
            slots[wrPtr] <= instWord;
        end
    end

    always_ff @(posedge Clock_pin or negedge rstN) begin
        if (!rstN) begin
            wrPtr      <= '0;
            rdPtr      <= '0;
            qCount     <= '0;
            instCredit <= 1'b0;
        end else begin
            if (instValid) begin
                wrPtr <= wrPtr + 1'b1;                 // wraps at depth
            end
            if (deq) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({instValid, deq})
                2'b10:   qCount <= qCount + 1'b1;
                2'b01:   qCount <= qCount - 1'b1;
                default: qCount <= qCount;
            endcase
            instCredit <= deq;                         // one credit per freed slot
        end
    end

endmodule

/* source/decodeStage.sv */
module decodeStage
    import isaPkg::*;
(
    input  logic   Clock_pin,
    input  logic   rstN,
    input  logic   qValid,
    input  instrT  qInstr,
    input  logic   xAdvance,
    input  logic   xValid,
    input  logic   xWrites,
    input  regIdxT xDest,
    input  wordT   xData,
    input  logic   rValid,
    input  regIdxT rDest,
    input  wordT   rData,
    input  wordT   rdDataA,
    input  wordT   rdDataB,
    output logic   qTake,
    output regIdxT rdAddrA,
    output regIdxT rdAddrB,
    output logic   dValid,
    output instrT  dInstr,
    output wordT   dOpA,
    output wordT   dOpB
);

    logic dAdvance;
    wordT fwdA;
    wordT fwdB;
    wordT opBNext;

    // newest pending write wins, execute before result before the file
    function automatic wordT fwdOperand(regIdxT addr, wordT fileData);
        if (xValid && xWrites && (xDest == addr)) begin
            return xData;
        end
        if (rValid && (rDest == addr)) begin
            return rData;                              // result slot always writes
        end
        return fileData;
    endfunction

    assign dAdvance = !dValid || xAdvance;
    assign qTake    = qValid && dAdvance;
    assign rdAddrA  = qInstr.regView.regA;
    assign rdAddrB  = qInstr.regView.regB;

    // ------------------------------------------------------------
    // operand selection
    // ------------------------------------------------------------
    always_comb begin
        fwdA = fwdOperand(rdAddrA, rdDataA);
        fwdB = fwdOperand(rdAddrB, rdDataB);
        if (usesImm(qInstr.regView.opcode)) begin
            opBNext = {{(WORD_W - REG_W){1'b0}}, qInstr.immView.imm};  // zero extended
        end else begin
            opBNext = fwdB;
        end
    end

    always_ff @(posedge Clock_pin or negedge rstN) begin
        if (!rstN) begin
            dValid <= 1'b0;
        end else if (dAdvance) begin
            dValid <= qValid;                          // bubble when queue is empty
        end
    end

    always_ff @(posedge Clock_pin) begin
        if (dAdvance) begin
            dInstr <= qInstr;
            dOpA   <= fwdA;
            dOpB   <= opBNext;
        end
    end

endmodule

/* source/executeStage.sv */
module executeStage
    import isaPkg::*;
(
    input  logic   Clock_pin,
    input  logic   rstN,
    input  logic   dValid,
    input  instrT  dInstr,
    input  wordT   dOpA,
    input  wordT   dOpB,
    input  logic   rAdvance,
    output logic   xAdvance,
    output logic   xValid,
    output logic   xWrites,
    output regIdxT xDest,
    output wordT   xData,
    output flagsT  xFlags
);

    opcodeT              op;
    logic [REG_W-1:0]    cnt;
    logic [REG_W-1:0]    rotCnt;
    logic [REG_W-1:0]    thruCnt;
    wordT                opA;
    wordT                opB;
    logic [WORD_W:0]     sum;
    logic [WORD_W:0]     diff;
    logic [2*WORD_W-1:0] rotLeft;
    logic [2*WORD_W-1:0] rotRight;
    logic [2*WORD_W+1:0] thruLeft;
    logic [2*WORD_W+1:0] thruRight;
    flagsT               statusReg;
    flagsT               curFlags;
    flagsT               nextFlags;
    wordT                aluData;
    logic                aluWrites;
    logic                setZn;

    assign op  = dInstr.regView.opcode;
    assign cnt = dInstr.immView.imm;

    // the instruction right ahead was still in decode when these operands
    // were read, so its result is picked up here from our own slot
    assign opA = (xValid && xWrites && (xDest == dInstr.regView.regA)) ? xData : dOpA;
    assign opB = (!usesImm(op) && xValid && xWrites && (xDest == dInstr.regView.regB)) ?
                 xData : dOpB;

    assign curFlags = xValid ? xFlags : statusReg;    // flags of the newest instruction

    // ------------------------------------------------------------
    // datapath pieces
    // ------------------------------------------------------------
    assign sum       = {1'b0, opA} + {1'b0, opB};
    assign diff      = {1'b0, opA} - {1'b0, opB};
    assign rotCnt    = (cnt >= REG_W'(WORD_W)) ? cnt - REG_W'(WORD_W) : cnt;  // mod 14
    assign thruCnt   = (cnt == '1) ? '0 : cnt;         // 15 is a full turn
    assign rotLeft   = {opA, opA} << rotCnt;
    assign rotRight  = {opA, opA} >> rotCnt;
    assign thruLeft  = {curFlags[FLAG_C], opA, curFlags[FLAG_C], opA} << thruCnt;
    assign thruRight = {curFlags[FLAG_C], opA, curFlags[FLAG_C], opA} >> thruCnt;

    always_comb begin
        aluData   = opA;
        aluWrites = 1'b1;
        nextFlags = curFlags;
        setZn     = 1'b0;
        case (op)
            OP_CPY: aluData = opB;
            OP_ADD, OP_ADDC: begin
                aluData           = sum[WORD_MSB:0];
                nextFlags[FLAG_C] = sum[WORD_W];                       // carry out
                nextFlags[FLAG_V] = (opA[WORD_MSB] == opB[WORD_MSB]) &&
                                    (sum[WORD_MSB] != opA[WORD_MSB]);
                setZn             = 1'b1;
            end
            OP_SUB, OP_SUBC: begin
                aluData           = diff[WORD_MSB:0];
                nextFlags[FLAG_C] = diff[WORD_W];                      // borrow
                nextFlags[FLAG_V] = (opA[WORD_MSB] != opB[WORD_MSB]) &&
                                    (diff[WORD_MSB] != opA[WORD_MSB]);
                setZn             = 1'b1;
            end
            OP_NOT, OP_AND, OP_OR, OP_XOR: begin
                case (op)
                    OP_NOT:  aluData = ~opA;
                    OP_AND:  aluData = opA & opB;
                    OP_OR:   aluData = opA | opB;
                    default: aluData = opA ^ opB;
                endcase
                nextFlags[FLAG_C] = 1'b0;
                nextFlags[FLAG_V] = 1'b0;
                setZn             = 1'b1;
            end
            OP_SHLL, OP_SHLA: aluData = opA << cnt;                    // 14 and up give 0
            OP_SHRL:          aluData = opA >> cnt;
            OP_SHRA:          aluData = wordT'($signed(opA) >>> cnt);
            OP_ROTL:          aluData = rotLeft[2*WORD_W-1:WORD_W];
            OP_ROTR:          aluData = rotRight[WORD_MSB:0];
            OP_RTLC:          {nextFlags[FLAG_C], aluData} = thruLeft[2*WORD_W+1:WORD_W+1];
            OP_RTRC:          {nextFlags[FLAG_C], aluData} = thruRight[WORD_W:0];
            default:          aluWrites = 1'b0;                        // NOP, nothing reported
        endcase
        if (setZn) begin
            nextFlags[FLAG_Z] = (aluData == '0);
            nextFlags[FLAG_N] = aluData[WORD_MSB];
        end
    end

    assign xAdvance = !xValid || rAdvance;

    always_ff @(posedge Clock_pin or negedge rstN) begin
        if (!rstN) begin
            xValid    <= 1'b0;
            statusReg <= '0;
        end else begin
            if (xAdvance) begin
                xValid <= dValid;
            end
            if (xValid && rAdvance) begin
                statusReg <= xFlags;                   // commit on the way into result
            end
        end
    end

    always_ff @(posedge Clock_pin) begin
        if (xAdvance) begin
            xDest   <= dInstr.regView.regA;
            xData   <= aluData;
            xFlags  <= nextFlags;
            xWrites <= aluWrites;
        end
    end

endmodule

/* source/resultStage.sv */
module resultStage
    import isaPkg::*;
    import flowPkg::*;
(
    input  logic   Clock_pin,
    input  logic   rstN,
    input  logic   xValid,
    input  logic   xWrites,
    input  regIdxT xDest,
    input  wordT   xData,
    input  flagsT  xFlags,
    input  logic   resCredit,
    input  regIdxT rdAddrA,
    input  regIdxT rdAddrB,
    output logic   rAdvance,
    output logic   rValid,
    output regIdxT rDest,
    output wordT   rData,
    output wordT   rdDataA,
    output wordT   rdDataB,
    output logic   resValid,
    output regIdxT resReg,
    output wordT   resData,
    output flagsT  resFlags
);

    wordT        regFile [REG_COUNT];
    flagsT       rFlags;
    creditCountT creditCnt;

    // write and report together, only with a credit in hand
    assign resValid = rValid && (creditCnt != '0);
    assign rAdvance = !rValid || resValid;
    assign resReg   = rDest;
    assign resData  = rData;
    assign resFlags = rFlags;
    assign rdDataA  = regFile[rdAddrA];
    assign rdDataB  = regFile[rdAddrB];

    always_ff @(posedge Clock_pin or negedge rstN) begin
        if (!rstN) begin
            rValid    <= 1'b0;
            creditCnt <= '0;
            for (int i = 0; i < REG_COUNT; i++) begin
                regFile[i] <= '0;
            end
        end else begin
            if (rAdvance) begin
                rValid <= xValid && xWrites;           // NOPs stop here
            end
            if (resValid) begin
                regFile[rDest] <= rData;
            end
            case ({resCredit, resValid})
                2'b10: begin
                    if (creditCnt < RES_CREDIT_MAX) begin
                        creditCnt <= creditCnt + 1'b1;
                    end
                end
                2'b01:   creditCnt <= creditCnt - 1'b1;
                default: creditCnt <= creditCnt;       // both or neither
            endcase
        end
    end

    always_ff @(posedge Clock_pin) begin
        if (rAdvance) begin
            rDest  <= xDest;
            rData  <= xData;
            rFlags <= xFlags;
        end
    end

endmodule

/* source/riscCore.sv */
module riscCore
    import isaPkg::*;
(
    input  logic   Clock_pin,
    input  logic   rstN,
    input  logic   instValid,
    input  instrT  instWord,
    output logic   instCredit,
    output logic   resValid,
    output regIdxT resReg,
    output wordT   resData,
    output flagsT  resFlags,
    input  logic   resCredit
);

    // ------------------------------------------------------------
    // queue to decode
    // ------------------------------------------------------------
    logic   qValid;
    instrT  qInstr;
    logic   qTake;

    // decode to execute
    logic   dValid;
    instrT  dInstr;
    wordT   dOpA;
    wordT   dOpB;
    logic   xAdvance;

    // execute to result, also forwarded back to decode
    logic   xValid;
    logic   xWrites;
    regIdxT xDest;
    wordT   xData;
    flagsT  xFlags;
    logic   rAdvance;

    // result slot and register file read ports
    logic   rValid;
    regIdxT rDest;
    wordT   rData;
    regIdxT rdAddrA;
    regIdxT rdAddrB;
    wordT   rdDataA;
    wordT   rdDataB;

    // ------------------------------------------------------------
    // pipeline
    // ------------------------------------------------------------
    instQueue    queueInst   (.*);
    decodeStage  decodeInst  (.*);
    executeStage executeInst (.*);
    resultStage  resultInst  (.*);

endmodule

/* verification/riscCore_properties.sv */
module riscCoreProperties
    import flowPkg::*;
(
    input logic Clock_pin,
    input logic rstN,
    input logic instValid,
    input logic instCredit,
    input logic resValid,
    input logic resCredit
);

    int sendCredits;                                   // sender's view of queue slots
    int resCredits;                                    // core's result credits

    always_ff @(posedge Clock_pin or negedge rstN) begin
        if (!rstN) begin
            sendCredits <= QUEUE_DEPTH;
            resCredits  <= 0;
        end else begin
            sendCredits <= sendCredits - int'(instValid) + int'(instCredit);
            if (resCredit && !resValid && resCredits < int'(RES_CREDIT_MAX)) begin
                resCredits <= resCredits + 1;
            end else if (resValid && !resCredit) begin
                resCredits <= resCredits - 1;
            end
        end
    end

    instNeedsCredit: assert property (@(posedge Clock_pin) disable iff (!rstN)
        instValid |-> sendCredits > 0) else $error("instruction sent without a credit");

    resNeedsCredit: assert property (@(posedge Clock_pin) disable iff (!rstN)
        resValid |-> resCredits > 0) else $error("result emitted without a credit");

    quietInReset: assert property (@(posedge Clock_pin)
        !rstN |-> !instCredit && !resValid) else $error("outputs active during reset");

endmodule

bind riscCore riscCoreProperties propsInst (.*);

/* verification/riscCoreTb.sv */
module riscCoreTb
    import isaPkg::*;
    import flowPkg::*;
;

    logic   Clock_pin = 1'b0;
    logic   rstN;
    logic   instValid;
    instrT  instWord;
    logic   instCredit;
    logic   resValid;
    regIdxT resReg;
    wordT   resData;
    flagsT  resFlags;
    logic   resCredit;

    int     senderCredits;
    int     mismatchCount;
    int     otherErrors;
    int     resultsSeen;
    logic   giveCredits;
    wordT   mRegs [REG_COUNT];
    flagsT  mFlags;
    regIdxT expReg [$];
    wordT   expData [$];
    flagsT  expFlags [$];
    opcodeT opList [17] = '{OP_CPY, OP_ADD, OP_SUB, OP_ADDC, OP_SUBC, OP_NOT, OP_AND,
                            OP_OR, OP_XOR, OP_SHLL, OP_SHRL, OP_SHLA, OP_SHRA,
                            OP_ROTL, OP_ROTR, OP_RTLC, OP_RTRC};

    riscCore riscCore_inst (.*);

    always #10 Clock_pin = ~Clock_pin;

    always @(posedge Clock_pin) begin
        #2;
        resCredit = giveCredits;                       // receiver frees a slot each cycle
    end

    // ------------------------------------------------------------
    // reference model predicts each result in program order
    // ------------------------------------------------------------
    function automatic void modelApply(instrT w);
        opcodeT      op;
        regIdxT      ra;
        logic [3:0]  n;
        wordT        a;
        wordT        b;
        wordT        r;
        logic [14:0] s;
        logic [14:0] v;
        flagsT       f;
        int          m;
        logic        setZn;
        op    = w.regView.opcode;
        ra    = w.regView.regA;
        n     = w.immView.imm;
        a     = mRegs[ra];
        b     = (op inside {OP_ADDC, OP_SUBC}) ? {10'b0, n} : mRegs[w.regView.regB];
        f     = mFlags;
        r     = a;
        setZn = 1'b0;
        case (op)
            OP_NOP: return;
            OP_CPY: r = b;
            OP_ADD, OP_ADDC: begin
                s     = {1'b0, a} + {1'b0, b};
                r     = s[13:0];
                f[3]  = s[14];
                f[1]  = (a[13] == b[13]) && (r[13] != a[13]);
                setZn = 1'b1;
            end
            OP_SUB, OP_SUBC: begin
                r     = a - b;
                f[3]  = (a < b);                       // borrow
                f[1]  = (a[13] != b[13]) && (r[13] != a[13]);
                setZn = 1'b1;
            end
            OP_NOT, OP_AND, OP_OR, OP_XOR: begin
                case (op)
                    OP_NOT:  r = ~a;
                    OP_AND:  r = a & b;
                    OP_OR:   r = a | b;
                    default: r = a ^ b;
                endcase
                f[3]  = 1'b0;
                f[1]  = 1'b0;
                setZn = 1'b1;
            end
            OP_SHLL, OP_SHLA: r = (n >= 14) ? 14'h0 : a << n;
            OP_SHRL:          r = (n >= 14) ? 14'h0 : a >> n;
            OP_SHRA: begin
                if (n >= 13) r = {14{a[13]}};
                else         r = (a >> n) | (a[13] ? ~(14'h3fff >> n) : 14'h0);
            end
            OP_ROTL: begin
                m = n % 14;
                r = (a << m) | (a >> (14 - m));
            end
            OP_ROTR: begin
                m = n % 14;
                r = (a >> m) | (a << (14 - m));
            end
            OP_RTLC, OP_RTRC: begin
                m = n % 15;
                v = {f[3], a};                         // carry joins the word
                if (op == OP_RTLC) v = (v << m) | (v >> (15 - m));
                else               v = (v >> m) | (v << (15 - m));
                {f[3], r} = v;
            end
            default: return;
        endcase
        if (setZn) begin
            f[0] = (r == 14'h0);
            f[2] = r[13];
        end
        mRegs[ra] = r;
        mFlags    = f;
        expReg.push_back(ra);
        expData.push_back(r);
        expFlags.push_back(f);
    endfunction

    function automatic instrT mkInst(opcodeT op, int ra, int field);
        instrT w;
        w.regView.opcode = op;
        w.regView.regA   = regIdxT'(ra);
        w.regView.regB   = regIdxT'(field);            // register B or immediate
        return w;
    endfunction

    // ------------------------------------------------------------
    // monitor on the stable half of the cycle
    // ------------------------------------------------------------
    always @(negedge Clock_pin) begin
        if (rstN) begin
            if (instCredit) senderCredits++;
            if (resValid) begin
                resultsSeen++;
                if (expData.size() == 0) begin
                    otherErrors++;
                    $display("unexpected result for R%0d with none pending", resReg);
                end else begin
                    if (resReg !== expReg[0]) begin
                        mismatchCount++;
                        $display("MISMATCH resReg: got %h expected %h", resReg, expReg[0]);
                    end
                    if (resData !== expData[0]) begin
                        mismatchCount++;
                        $display("MISMATCH resData: got %h expected %h", resData, expData[0]);
                    end
                    if (resFlags !== expFlags[0]) begin
                        mismatchCount++;
                        $display("MISMATCH resFlags: got %h expected %h", resFlags, expFlags[0]);
                    end
                    void'(expReg.pop_front());
                    void'(expData.pop_front());
                    void'(expFlags.pop_front());
                end
            end
        end
    end

    task automatic abortRun(string why);
        $display("%s", why);
        $display("errors: %0d mismatches, %0d other", mismatchCount, otherErrors + 1);
        $display("Test FAILED");
        $finish;
    endtask

    task automatic driveOne(instrT w);
        instValid = 1'b1;
        instWord  = w;
        senderCredits--;
        modelApply(w);
    endtask

    // one instruction per cycle while credits last
    task automatic sendInst(instrT w);
        int t;
        t = 0;
        @(posedge Clock_pin);
        #2;
        while (senderCredits == 0) begin
            instValid = 1'b0;
            @(posedge Clock_pin);
            #2;
            t++;
            if (t > 200) abortRun("no instruction credit came back in time");
        end
        driveOne(w);
    endtask

    task automatic idleInput();
        @(posedge Clock_pin);
        #2;
        instValid = 1'b0;
    endtask

    task automatic drainResults();
        int t;
        t = 0;
        idleInput();
        while (expData.size() != 0) begin
            @(posedge Clock_pin);
            t++;
            if (t > 300) abortRun("expected results did not arrive in time");
        end
    endtask

    task automatic applyReset();
        instValid   = 1'b0;
        giveCredits = 1'b0;
        rstN        = 1'b0;
        repeat (5) @(posedge Clock_pin);
        #2;
        rstN = 1'b1;
        foreach (mRegs[i]) mRegs[i] = '0;
        mFlags        = '0;
        senderCredits = QUEUE_DEPTH;
    endtask

    // ------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------
    task automatic resetStateTest();
        giveCredits = 1'b1;
        sendInst(mkInst(OP_ADD, 1, 2));                // zero with only Z set
        drainResults();
    endtask

    task automatic arithTest();
        sendInst(mkInst(OP_ADDC, 1, 7));
        sendInst(mkInst(OP_ADDC, 1, 15));
        sendInst(mkInst(OP_ADDC, 2, 1));
        sendInst(mkInst(OP_SHLL, 2, 13));              // most negative value
        sendInst(mkInst(OP_SUBC, 4, 1));               // borrow
        sendInst(mkInst(OP_ADDC, 5, 1));
        sendInst(mkInst(OP_ADD, 5, 4));                // carry out to zero
        sendInst(mkInst(OP_CPY, 6, 2));
        sendInst(mkInst(OP_SUBC, 6, 1));               // signed overflow
        sendInst(mkInst(OP_ADDC, 6, 1));
        sendInst(mkInst(OP_SUB, 1, 2));
        sendInst(mkInst(OP_ADD, 2, 2));
        sendInst(mkInst(OP_SUB, 3, 1));
        drainResults();
    endtask

    task automatic logicTest();
        sendInst(mkInst(OP_ADDC, 7, 12));
        sendInst(mkInst(OP_NOT, 8, 0));
        sendInst(mkInst(OP_AND, 8, 7));
        sendInst(mkInst(OP_OR, 9, 8));
        sendInst(mkInst(OP_XOR, 9, 9));
        sendInst(mkInst(OP_CPY, 10, 8));
        sendInst(mkInst(OP_NOT, 10, 0));
        sendInst(mkInst(OP_XOR, 7, 10));
        sendInst(mkInst(OP_AND, 7, 9));
        drainResults();
    endtask

    task automatic shiftTest();
        opcodeT ops [8] = '{OP_SHLL, OP_SHLA, OP_SHRL, OP_SHRA,
                            OP_ROTL, OP_ROTR, OP_RTLC, OP_RTRC};
        int     counts [5] = '{0, 1, 13, 14, 15};
        sendInst(mkInst(OP_ADDC, 12, 13));
        sendInst(mkInst(OP_SHLL, 12, 10));
        sendInst(mkInst(OP_ADDC, 12, 5));
        foreach (ops[i]) begin
            foreach (counts[j]) begin
                sendInst(mkInst(OP_CPY, 11, 12));
                sendInst(mkInst(ops[i], 11, counts[j]));
            end
        end
        sendInst(mkInst(OP_SUBC, 13, 1));              // carry set for the chains
        sendInst(mkInst(OP_SHLL, 13, 13));             // only the top bit left beside the carry
        repeat (4) sendInst(mkInst(OP_RTLC, 13, 1));
        repeat (4) sendInst(mkInst(OP_RTRC, 13, 3));
        drainResults();
    endtask

    task automatic nopTest();
        sendInst(mkInst(OP_NOP, 3, 4));
        sendInst(mkInst(OP_ADDC, 14, 9));
        sendInst(mkInst(OP_NOP, 14, 15));
        sendInst(mkInst(OP_NOP, 0, 0));
        sendInst(mkInst(OP_ADD, 14, 14));
        sendInst(mkInst(OP_NOP, 7, 7));
        sendInst(mkInst(OP_SUB, 15, 14));
        drainResults();
    endtask

    task automatic backPressureTest();
        instrT w;
        int    sent;
        int    seenBefore;
        applyReset();
        seenBefore = resultsSeen;
        sent       = 0;
        repeat (60) begin
            @(posedge Clock_pin);
            #2;
            if (senderCredits > 0 && sent < 12) begin
                w                = instrT'($urandom);
                w.regView.opcode = opList[$urandom % 17];
                driveOne(w);
                sent++;
            end else begin
                instValid = 1'b0;
            end
        end
        if (sent != QUEUE_DEPTH + 3) begin
            otherErrors++;
            $display("core accepted %0d instructions without result credits", sent);
        end
        if (resultsSeen != seenBefore) begin
            otherErrors++;
            $display("a result appeared while no result credit was given");
        end
        giveCredits = 1'b1;
        while (sent < 12) begin
            w                = instrT'($urandom);
            w.regView.opcode = opList[$urandom % 17];
            sendInst(w);
            sent++;
        end
        drainResults();
    endtask

    initial begin
        void'($urandom(74));
        rstN          = 1'b0;
        instValid     = 1'b0;
        instWord      = '0;
        resCredit     = 1'b0;
        giveCredits   = 1'b0;
        mismatchCount = 0;
        otherErrors   = 0;
        resultsSeen   = 0;
        applyReset();
        resetStateTest();
        arithTest();
        logicTest();
        shiftTest();
        nopTest();
        backPressureTest();
        $display("errors: %0d mismatches, %0d other", mismatchCount, otherErrors);
        if (mismatchCount == 0 && otherErrors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* src.f */
source/isaPkg.sv
source/flowPkg.sv
source/instQueue.sv
source/decodeStage.sv
source/executeStage.sv
source/resultStage.sv
source/riscCore.sv
verification/riscCore_properties.sv
verification/riscCoreTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= riscCoreTb
BUILD_DIR ?= obj_dir
FILELIST  ?= src.f
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "Test FAILED" $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf $(BUILD_DIR) $(LOG)
